/* Makefile */
VERILATOR  ?= verilator
TOP        ?= tb_l1_cache
RTL_TOP    ?= l1_cache
FILELIST   ?= l1_cache.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= -Wall --timing
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
FAIL_MSG   ?= Errors found
PASS_MSG   ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)
	$(VERILATOR) --lint-only $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* hw/cache_array.sv */
// direct mapped frame storage with async read and bit masked write
`default_nettype none

`include "l1_cache_defs.svh"

module cache_array (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic [l1_cache_pkg::IDX_W-1:0] idx,
    input  l1_cache_pkg::cache_frame_t     wframe,
    input  l1_cache_pkg::cache_frame_t     wmask,
    input  logic                           wen,
    output l1_cache_pkg::cache_frame_t     rframe
);
    import l1_cache_pkg::*;

    // one frame per set
    cache_frame_t frames [`N_SETS];
    cache_frame_t merged;

    // frame at the selected set, visible in the same cycle
    assign rframe = frames[idx];

    // only bits set in the mask take the new value
    assign merged = (frames[idx] & ~wmask) | (wframe & wmask);

    always_ff @(posedge CLK) begin
        if (wen) begin
            frames[idx] <= merged;
        end
    end

    // a write must target a known set
    a_wr_idx_known: assert property (
        @(posedge CLK) disable iff (!nRST) wen |-> !$isunknown(idx)
    );

endmodule

`default_nettype wire

/* hw/cache_ctrl.sv */
// cache FSM: init clear, hit service, eviction, fetch, block update and flush walk
`default_nettype none

`include "l1_cache_defs.svh"

module cache_ctrl (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          flush,
    output logic                          flush_done,
    input  l1_cache_pkg::proc_req_t       proc_req,
    output logic                          proc_busy,
    output l1_cache_pkg::word_t           proc_rdata,
    input  l1_cache_pkg::cache_frame_t    rd_frame,
    output logic [l1_cache_pkg::IDX_W-1:0] arr_idx,
    output l1_cache_pkg::cache_frame_t    arr_wframe,
    output l1_cache_pkg::cache_frame_t    arr_wmask,
    output logic                          arr_wen,
    output l1_cache_pkg::mem_req_t        req,
    output logic                          req_push,
    input  logic                          req_full,
    input  logic                          req_empty,
    input  l1_cache_pkg::fill_blk_t       fill,
    input  logic                          fill_valid,
    output logic                          fill_pop
);
    import l1_cache_pkg::*;

    cache_state_t state, next_state;
    // walks the sets in INIT and FLUSH, msb marks the end of a flush walk
    logic [IDX_W:0] set_cnt;
    logic           cnt_en;
    logic           fetch_pend;
    logic           flush_req;
    logic           access;
    logic           hit;
    logic           walk_end;
    cache_addr_t    fill_addr;
    word_t          bit_en;

    function automatic word_t blk_addr(input logic [TAG_W-1:0] tag,
                                       input logic [IDX_W-1:0] idx);
        cache_addr_t a;
        a     = '0;
        a.tag = tag;
        a.idx = idx;
        return a;
    endfunction

    assign access     = proc_req.ren || proc_req.wen;
    assign hit        = rd_frame.valid && (rd_frame.tag == proc_req.addr.tag);
    assign fill_addr  = cache_addr_t'(fill.addr);
    assign walk_end   = (set_cnt == (IDX_W+1)'(`N_SETS - 1));
    assign proc_rdata = rd_frame.data[proc_req.addr.woff];

    // byte enables widened to one bit per data bit
    always_comb begin
        for (int b = 0; b < `WORD_W/8; b++) begin
            bit_en[8*b +: 8] = {8{proc_req.byte_en[b]}};
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state      <= INIT;
            set_cnt    <= '0;
            fetch_pend <= 1'b0;
            flush_req  <= 1'b0;
        end else begin
            state <= next_state;
            if (next_state != state) begin
                set_cnt <= '0;
            end else if (cnt_en) begin
                set_cnt <= set_cnt + 1'b1;
            end
            // one fetch at a time, retired by the block update
            if (state == FETCH && !req_full) begin
                fetch_pend <= 1'b1;
            end else if (state == UPDATE) begin
                fetch_pend <= 1'b0;
            end
            if (state == HIT && next_state == FLUSH) begin
                flush_req <= 1'b0;
            end else if (flush) begin
                flush_req <= 1'b1;
            end
        end
    end

    always_comb begin
        next_state = state;
        proc_busy  = 1'b1;
        flush_done = 1'b0;
        arr_idx    = proc_req.addr.idx;
        arr_wen    = 1'b0;
        arr_wframe = '0;
        arr_wmask  = '0;
        req        = '0;
        req_push   = 1'b0;
        fill_pop   = 1'b0;
        cnt_en     = 1'b0;
        case (state)
            INIT: begin
                arr_idx   = set_cnt[IDX_W-1:0];
                arr_wen   = 1'b1;
                arr_wmask = '1;
                cnt_en    = 1'b1;
                if (walk_end) begin
                    next_state = HIT;
                end
            end
            HIT: begin
                if (fill_valid) begin
                    next_state = UPDATE;
                end else if ((flush_req || flush) && !fetch_pend) begin
                    next_state = FLUSH;
                end else if (access && hit) begin
                    proc_busy = 1'b0;
                    if (proc_req.wen) begin
                        arr_wen                             = 1'b1;
                        arr_wframe.dirty                    = 1'b1;
                        arr_wframe.data[proc_req.addr.woff] = proc_req.wdata;
                        arr_wmask.dirty                     = 1'b1;
                        arr_wmask.data[proc_req.addr.woff]  = bit_en;
                    end
                end else if (access && !fetch_pend) begin
                    next_state = (rd_frame.valid && rd_frame.dirty) ? WB : FETCH;
                end
            end
            WB: begin
                req.write = 1'b1;
                req.addr  = blk_addr(rd_frame.tag, proc_req.addr.idx);
                req.data  = rd_frame.data;
                if (!req_full) begin
                    req_push        = 1'b1;
                    // victim leaves the array clean and invalid
                    arr_wen         = 1'b1;
                    arr_wmask.valid = 1'b1;
                    arr_wmask.dirty = 1'b1;
                    next_state      = FETCH;
                end
            end
            FETCH: begin
                req.addr = blk_addr(proc_req.addr.tag, proc_req.addr.idx);
                if (!req_full) begin
                    req_push   = 1'b1;
                    next_state = HIT;
                end
            end
            UPDATE: begin
                arr_idx          = fill_addr.idx;
                arr_wen          = 1'b1;
                arr_wmask        = '1;
                arr_wframe.valid = 1'b1;
                arr_wframe.tag   = fill_addr.tag;
                arr_wframe.data  = fill.data;
                fill_pop         = 1'b1;
                next_state       = HIT;
            end
            FLUSH: begin
                arr_idx = set_cnt[IDX_W-1:0];
                if (set_cnt[IDX_W]) begin
                    // all sets visited, wait for the queue to drain
                    if (req_empty) begin
                        flush_done = 1'b1;
                        next_state = HIT;
                    end
                end else if (rd_frame.valid && rd_frame.dirty) begin
                    req.write = 1'b1;
                    req.addr  = blk_addr(rd_frame.tag, set_cnt[IDX_W-1:0]);
                    req.data  = rd_frame.data;
                    if (!req_full) begin
                        req_push  = 1'b1;
                        arr_wen   = 1'b1;
                        arr_wmask = '1;
                        cnt_en    = 1'b1;
                    end
                end else begin
                    arr_wen   = 1'b1;
                    arr_wmask = '1;
                    cnt_en    = 1'b1;
                end
            end
            default: next_state = INIT;
        endcase
    end

    a_no_push_when_full: assert property (
        @(posedge CLK) disable iff (!nRST) req_push |-> !req_full
    );

endmodule

`default_nettype wire

/* hw/fill_queue.sv */
// fill queue gathering returned read words into blocks for the array update
`default_nettype none

`include "l1_cache_defs.svh"

module fill_queue (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    rd_word,
    input  l1_cache_pkg::word_t     rd_addr,
    input  logic                    rd_last,
    input  l1_cache_pkg::word_t     mem_rdata,
    output l1_cache_pkg::fill_blk_t fill,
    output logic                    fill_valid,
    input  logic                    fill_pop
);
    import l1_cache_pkg::*;

    localparam int PTR_W = $clog2(`REQ_DEPTH);

    fill_blk_t                q [`REQ_DEPTH];
    logic [PTR_W:0]           wptr;
    logic [PTR_W:0]           rptr;
    logic [WOFF_W-1:0]        gcnt;
    word_t [`BLOCK_WORDS-1:0] gather;
    word_t [`BLOCK_WORDS-1:0] blk_data;
    logic                     fq_full;

    assign fq_full    = ((wptr - rptr) == (PTR_W+1)'(`REQ_DEPTH));
    assign fill_valid = (wptr != rptr);
    assign fill       = q[rptr[PTR_W-1:0]];

    // gathered words plus the word arriving now
    always_comb begin
        blk_data       = gather;
        blk_data[gcnt] = mem_rdata;
    end

    always_ff @(posedge CLK) begin
        if (rd_word) begin
            gather[gcnt] <= mem_rdata;
        end
        if (rd_last) begin
            q[wptr[PTR_W-1:0]] <= '{addr: rd_addr, data: blk_data};
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wptr <= '0;
            rptr <= '0;
            gcnt <= '0;
        end else begin
            if (rd_word) begin
                gcnt <= rd_last ? '0 : gcnt + 1'b1;
            end
            if (rd_last) begin
                wptr <= wptr + 1'b1;
            end
            if (fill_pop) begin
                rptr <= rptr + 1'b1;
            end
        end
    end

    a_no_block_when_full: assert property (
        @(posedge CLK) disable iff (!nRST) rd_last |-> !fq_full
    );

endmodule

`default_nettype wire

/* hw/l1_cache.sv */
// top level of the L1 data cache, wiring controller, frame array and queues
`default_nettype none

module l1_cache (
    input  logic                    CLK,
    input  logic                    nRST,
    input  logic                    flush,
    output logic                    flush_done,
    input  l1_cache_pkg::proc_req_t proc_req,
    output logic                    proc_busy,
    output l1_cache_pkg::word_t     proc_rdata,
    output logic                    mem_ren,
    output logic                    mem_wen,
    output l1_cache_pkg::word_t     mem_addr,
    output l1_cache_pkg::word_t     mem_wdata,
    input  logic                    mem_busy,
    input  l1_cache_pkg::word_t     mem_rdata
);
    import l1_cache_pkg::*;

    // frame array port
    cache_frame_t     rd_frame;
    cache_frame_t     arr_wframe;
    cache_frame_t     arr_wmask;
    logic [IDX_W-1:0] arr_idx;
    logic             arr_wen;

    // controller to request queue
    mem_req_t req;
    logic     req_push;
    logic     req_full;
    logic     req_empty;

    // returned read words and finished blocks
    logic      rd_word;
    logic      rd_last;
    word_t     rd_addr;
    fill_blk_t fill;
    logic      fill_valid;
    logic      fill_pop;

    cache_ctrl i_ctrl (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .flush_done (flush_done),
        .proc_req   (proc_req),
        .proc_busy  (proc_busy),
        .proc_rdata (proc_rdata),
        .rd_frame   (rd_frame),
        .arr_idx    (arr_idx),
        .arr_wframe (arr_wframe),
        .arr_wmask  (arr_wmask),
        .arr_wen    (arr_wen),
        .req        (req),
        .req_push   (req_push),
        .req_full   (req_full),
        .req_empty  (req_empty),
        .fill       (fill),
        .fill_valid (fill_valid),
        .fill_pop   (fill_pop)
    );

    cache_array i_array (
        .CLK    (CLK),
        .nRST   (nRST),
        .idx    (arr_idx),
        .wframe (arr_wframe),
        .wmask  (arr_wmask),
        .wen    (arr_wen),
        .rframe (rd_frame)
    );

    mem_req_queue i_req_q (
        .CLK       (CLK),
        .nRST      (nRST),
        .req       (req),
        .req_push  (req_push),
        .req_full  (req_full),
        .req_empty (req_empty),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_busy  (mem_busy),
        .mem_rdata (mem_rdata),
        .rd_word   (rd_word),
        .rd_addr   (rd_addr),
        .rd_last   (rd_last)
    );

    fill_queue i_fill_q (
        .CLK        (CLK),
        .nRST       (nRST),
        .rd_word    (rd_word),
        .rd_addr    (rd_addr),
        .rd_last    (rd_last),
        .mem_rdata  (mem_rdata),
        .fill       (fill),
        .fill_valid (fill_valid),
        .fill_pop   (fill_pop)
    );

endmodule

`default_nettype wire

/* hw/l1_cache_defs.svh */
// geometry and timing defines for the L1 data cache
`ifndef L1_CACHE_DEFS_SVH
`define L1_CACHE_DEFS_SVH

// data word width in bits
`define WORD_W 32

// words per cache block
`define BLOCK_WORDS 2

// direct mapped, one frame per set
`define N_SETS 64

// entries in the request queue and the fill queue
`define REQ_DEPTH 4

// busy cycles per memory word, used by the memory model
`define MEM_LATENCY 3

`endif

/* hw/l1_cache_pkg.sv */
// address, frame, request, fill and controller state types for the L1 cache
`default_nettype none

`include "l1_cache_defs.svh"

package l1_cache_pkg;

    // address field widths
    localparam int IDX_W  = $clog2(`N_SETS);
    localparam int WOFF_W = $clog2(`BLOCK_WORDS);
    localparam int TAG_W  = `WORD_W - IDX_W - WOFF_W - 2;

    typedef logic [`WORD_W-1:0] word_t;

    typedef struct packed {
        logic [TAG_W-1:0]  tag;
        logic [IDX_W-1:0]  idx;
        logic [WOFF_W-1:0] woff;
        logic [1:0]        boff;
    } cache_addr_t;

    typedef struct packed {
        logic                     valid;
        logic                     dirty;
        logic [TAG_W-1:0]         tag;
        word_t [`BLOCK_WORDS-1:0] data;
    } cache_frame_t;

    // processor side request
    typedef struct packed {
        logic                  ren;
        logic                  wen;
        cache_addr_t           addr;
        word_t                 wdata;
        logic [`WORD_W/8-1:0]  byte_en;
    } proc_req_t;

    // one block transfer, addr is block aligned
    typedef struct packed {
        logic                     write;
        word_t                    addr;
        word_t [`BLOCK_WORDS-1:0] data;
    } mem_req_t;

    typedef struct packed {
        word_t                    addr;
        word_t [`BLOCK_WORDS-1:0] data;
    } fill_blk_t;

    typedef enum logic [2:0] {
        INIT,
        HIT,
        WB,
        FETCH,
        UPDATE,
        FLUSH
    } cache_state_t;

endpackage

`default_nettype wire

/* hw/mem_req_queue.sv */
// block request queue, issuing queued block reads and writes word by word to memory
`default_nettype none

`include "l1_cache_defs.svh"

module mem_req_queue (
    input  logic                   CLK,
    input  logic                   nRST,
    input  l1_cache_pkg::mem_req_t req,
    input  logic                   req_push,
    output logic                   req_full,
    output logic                   req_empty,
    output logic                   mem_ren,
    output logic                   mem_wen,
    output l1_cache_pkg::word_t    mem_addr,
    output l1_cache_pkg::word_t    mem_wdata,
    input  logic                   mem_busy,
    input  l1_cache_pkg::word_t    mem_rdata,
    output logic                   rd_word,
    output l1_cache_pkg::word_t    rd_addr,
    output logic                   rd_last
);
    import l1_cache_pkg::*;

    localparam int PTR_W = $clog2(`REQ_DEPTH);

    mem_req_t          q [`REQ_DEPTH];
    mem_req_t          head;
    logic [PTR_W:0]    wptr;
    logic [PTR_W:0]    rptr;
    // word within the head block
    logic [WOFF_W-1:0] wcnt;
    logic              word_done;
    logic              last_word;

    assign head      = q[rptr[PTR_W-1:0]];
    assign req_empty = (wptr == rptr);
    assign req_full  = ((wptr - rptr) == (PTR_W+1)'(`REQ_DEPTH));

    // head block presented one word at a time
    assign mem_ren   = !req_empty && !head.write;
    assign mem_wen   = !req_empty && head.write;
    assign mem_addr  = head.addr + (word_t'(wcnt) << 2);
    assign mem_wdata = head.data[wcnt];

    assign word_done = (mem_ren || mem_wen) && !mem_busy;
    assign last_word = (wcnt == WOFF_W'(`BLOCK_WORDS - 1));

    // completed read words go on to the fill queue
    assign rd_word = mem_ren && !mem_busy;
    assign rd_addr = head.addr;
    assign rd_last = rd_word && last_word;

    always_ff @(posedge CLK) begin
        if (req_push) begin
            q[wptr[PTR_W-1:0]] <= req;
        end
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            wptr <= '0;
            rptr <= '0;
            wcnt <= '0;
        end else begin
            if (req_push) begin
                wptr <= wptr + 1'b1;
            end
            if (word_done) begin
                if (last_word) begin
                    wcnt <= '0;
                    rptr <= rptr + 1'b1;
                end else begin
                    wcnt <= wcnt + 1'b1;
                end
            end
        end
    end

    a_no_wen_when_empty: assert property (
        @(posedge CLK) disable iff (!nRST) mem_wen |-> !req_empty
    );

    // memory must return defined data on a completed read word
    a_rdata_known: assert property (
        @(posedge CLK) disable iff (!nRST) rd_word |-> !$isunknown(mem_rdata)
    );

endmodule

`default_nettype wire

/* l1_cache.f */
+incdir+hw
hw/l1_cache_pkg.sv
hw/cache_array.sv
hw/mem_req_queue.sv
hw/fill_queue.sv
hw/cache_ctrl.sv
hw/l1_cache.sv
verification/mem_model.sv
verification/tb_l1_cache.sv

/* verification/mem_model.sv */
// word-wide memory model with fixed busy latency per word and a backing array
`default_nettype none

`include "l1_cache_defs.svh"

module mem_model (
    input  logic                CLK,
    input  logic                nRST,
    input  logic                mem_ren,
    input  logic                mem_wen,
    input  l1_cache_pkg::word_t mem_addr,
    input  l1_cache_pkg::word_t mem_wdata,
    output logic                mem_busy,
    output l1_cache_pkg::word_t mem_rdata
);
    timeunit 1ns;
    timeprecision 1ps;
    import l1_cache_pkg::*;

    // 16 KB of words
    localparam int MEM_WORDS = 4096;

    word_t       mem [MEM_WORDS];
    logic [3:0]  lat_cnt;
    logic [11:0] widx;
    logic        active;

    assign active    = mem_ren || mem_wen;
    assign widx      = mem_addr[13:2];
    // busy for MEM_LATENCY cycles, word completes on the cycle after
    assign mem_busy  = active && (lat_cnt != 4'(`MEM_LATENCY));
    assign mem_rdata = mem[widx];

    // contents depend on the full word index
    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] = (32'(i) * 32'h9E37_79B9) ^ 32'h0F0F_5A5A;
        end
    end

    always @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            lat_cnt <= '0;
        end else if (active && mem_busy) begin
            lat_cnt <= lat_cnt + 4'd1;
        end else begin
            lat_cnt <= '0;
        end
    end

    always @(posedge CLK) begin
        if (mem_wen && !mem_busy) begin
            mem[widx] <= mem_wdata;
        end
    end

endmodule

`default_nettype wire

/* verification/tb_l1_cache.sv */
// testbench for the L1 data cache with shadow memory reference, checker and watchdog
`default_nettype none

`include "l1_cache_defs.svh"

module tb_l1_cache;
    timeunit 1ns;
    timeprecision 1ps;
    import l1_cache_pkg::*;

    localparam int CLK_HALF   = 10;
    localparam int RST_CYCLES = 8;
    localparam int SEED       = 38670;
    localparam int N_RANDOM   = 400;
    // the flush walk counts as one operation per set
    localparam int N_OPS      = 2 + 8 + 3 + 16 + N_RANDOM + `N_SETS;
    localparam int OP_CYCLES  = 2 * `BLOCK_WORDS * (`MEM_LATENCY + 1) + 8;

    logic      CLK;
    logic      nRST;
    logic      flush;
    logic      flush_done;
    logic      proc_busy;
    logic      mem_ren;
    logic      mem_wen;
    logic      mem_busy;
    proc_req_t proc_req;
    word_t     proc_rdata;
    word_t     mem_addr;
    word_t     mem_wdata;
    word_t     mem_rdata;

    word_t shadow [word_t];
    word_t got_q [$];
    word_t exp_q [$];
    string msg_q [$];
    int    err_cnt = 0;
    int    chk_cnt = 0;
    int    test_cnt = 0;
    int    test_err = 0;

    l1_cache i_dut (
        .CLK        (CLK),
        .nRST       (nRST),
        .flush      (flush),
        .flush_done (flush_done),
        .proc_req   (proc_req),
        .proc_busy  (proc_busy),
        .proc_rdata (proc_rdata),
        .mem_ren    (mem_ren),
        .mem_wen    (mem_wen),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata),
        .mem_busy   (mem_busy),
        .mem_rdata  (mem_rdata)
    );

    mem_model i_mem (
        .CLK       (CLK),
        .nRST      (nRST),
        .mem_ren   (mem_ren),
        .mem_wen   (mem_wen),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_busy  (mem_busy),
        .mem_rdata (mem_rdata)
    );

    initial CLK = 1'b0;
    always #CLK_HALF CLK = ~CLK;

    // expected word at addr once wdata is merged under byte enables be
    function automatic word_t merged_word(input word_t addr, input word_t wdata,
                                          input logic [3:0] be);
        word_t wa;
        word_t w;
        wa = addr & ~32'h3;
        if (shadow.exists(wa)) begin
            w = shadow[wa];
        end else begin
            w = (32'(wa[13:2]) * 32'h9E37_79B9) ^ 32'h0F0F_5A5A;
        end
        for (int b = 0; b < 4; b++) begin
            if (be[b]) begin
                w[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return w;
    endfunction

    task automatic check_value(input word_t got, input word_t exp, input string msg);
        chk_cnt++;
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s, got %h, expected %h", $time, msg, got, exp);
            err_cnt++;
        end
    endtask

    // one processor access, held until the cache drops proc_busy
    task automatic cpu_access(input logic wr, input word_t addr, input word_t wdata,
                              input logic [3:0] be);
        word_t exp;
        bit    done;
        exp = merged_word(addr, wdata, wr ? be : 4'b0000);
        if (wr) begin
            shadow[addr & ~32'h3] = exp;
        end
        @(posedge CLK);
        proc_req.ren     <= !wr;
        proc_req.wen     <= wr;
        proc_req.addr    <= cache_addr_t'(addr);
        proc_req.wdata   <= wdata;
        proc_req.byte_en <= be;
        done = 1'b0;
        while (!done) begin
            @(negedge CLK);
            if (!proc_busy) begin
                done = 1'b1;
                if (!wr) begin
                    got_q.push_back(proc_rdata);
                    exp_q.push_back(exp);
                    msg_q.push_back($sformatf("read of %h", addr));
                end
            end
        end
        @(posedge CLK);
        proc_req.ren <= 1'b0;
        proc_req.wen <= 1'b0;
    endtask

    task automatic end_test(input string name);
        @(posedge CLK);
        @(negedge CLK);
        test_cnt++;
        if (err_cnt == test_err) begin
            $display("test %0d %s: passed", test_cnt, name);
        end else begin
            $display("test %0d %s: failed, %0d errors", test_cnt, name, err_cnt - test_err);
        end
        test_err = err_cnt;
    endtask

    // read results captured at negedge are compared at the next rising edge
    always @(posedge CLK) begin
        while (got_q.size() > 0) begin
            check_value(got_q.pop_front(), exp_q.pop_front(), msg_q.pop_front());
        end
    end

    initial begin
        #((RST_CYCLES + N_OPS * OP_CYCLES) * 2 * CLK_HALF);
        $display("timeout: the tests did not finish within the expected number of cycles");
        $display("Errors found");
        $finish;
    end

    initial begin
        word_t flush_addr [8];
        word_t addr;
        int    pulses;
        int    waited;
        void'($urandom(SEED));
        nRST     = 1'b0;
        flush    = 1'b0;
        proc_req = '0;
        repeat (RST_CYCLES) @(posedge CLK);
        nRST <= 1'b1;

        cpu_access(1'b0, 32'h0000_0100, '0, 4'h0);
        cpu_access(1'b0, 32'h0000_0100, '0, 4'h0);
        end_test("untouched read");

        cpu_access(1'b1, 32'h0000_0200, 32'h1122_3344, 4'b0001);
        cpu_access(1'b0, 32'h0000_0200, '0, 4'h0);
        cpu_access(1'b1, 32'h0000_0200, 32'hAABB_CCDD, 4'b0011);
        cpu_access(1'b0, 32'h0000_0200, '0, 4'h0);
        cpu_access(1'b1, 32'h0000_0200, 32'h5566_7788, 4'b1100);
        cpu_access(1'b0, 32'h0000_0200, '0, 4'h0);
        cpu_access(1'b1, 32'h0000_0200, 32'hDEAD_BEEF, 4'b1111);
        cpu_access(1'b0, 32'h0000_0200, '0, 4'h0);
        end_test("byte enables");

        // same index, tag differs by one
        cpu_access(1'b1, 32'h0000_0300, 32'hCAFE_F00D, 4'hF);
        cpu_access(1'b0, 32'h0000_0500, '0, 4'h0);
        cpu_access(1'b0, 32'h0000_0300, '0, 4'h0);
        end_test("eviction");

        for (int k = 0; k < 8; k++) begin
            flush_addr[k] = 32'h2000 + 32'(k * 8) + 32'((k % 2) * 4);
            cpu_access(1'b1, flush_addr[k], $urandom, 4'hF);
        end
        @(posedge CLK);
        flush <= 1'b1;
        @(posedge CLK);
        flush <= 1'b0;
        pulses = 0;
        waited = 0;
        while (pulses == 0 && waited < `N_SETS * OP_CYCLES) begin
            @(negedge CLK);
            if (flush_done) begin
                pulses++;
            end
            waited++;
        end
        if (pulses == 0) begin
            $display("flush did not finish: flush_done never went high");
            err_cnt++;
        end
        // watch for a repeated pulse
        repeat (OP_CYCLES) begin
            @(negedge CLK);
            if (flush_done) begin
                pulses++;
            end
        end
        check_value(word_t'(pulses), 32'd1, "flush_done pulse count");
        foreach (shadow[a]) begin
            check_value(i_mem.mem[a[13:2]], shadow[a], $sformatf("memory at %h after flush", a));
        end
        for (int k = 0; k < 8; k++) begin
            cpu_access(1'b0, flush_addr[k], '0, 4'h0);
        end
        end_test("flush");

        // four tags on four sets keep evicting each other
        repeat (N_RANDOM) begin
            addr = 32'h1000 | (($urandom % 4) << 9) | (($urandom % 4) << 3)
                 | (($urandom % 2) << 2);
            if ($urandom % 2) begin
                cpu_access(1'b1, addr, $urandom, 4'($urandom % 16));
            end else begin
                cpu_access(1'b0, addr, '0, 4'h0);
            end
        end
        end_test("random traffic");

        $display("%0d tests, %0d checks, %0d errors", test_cnt, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
